// File: src/arp_pkg.sv
package arp_pkg;

  localparam int ARP_HDR_LEN   = 28; // header bytes on the wire.
  localparam int ARP_PLD_LEN   = 46; // header plus zero pad.
  localparam int CACHE_ENTRIES = 8;
  localparam int CACHE_IDX_W   = 3;

  localparam logic [15:0] HTYPE_ETH  = 16'h0001;
  localparam logic [15:0] PTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  HLEN_MAC   = 8'd6;
  localparam logic [7:0]  PLEN_IPV4  = 8'd4;
  localparam logic [15:0] OPER_REQ   = 16'd1;
  localparam logic [15:0] OPER_REP   = 16'd2;

  // byte [0] is the last octet of the address.
  typedef logic [3:0][7:0] ipv4_t;
  typedef logic [5:0][7:0] mac_t;

  localparam mac_t BCAST_MAC = '1;

  // fields in wire order, first field in the top bits.
  typedef struct packed {
    logic [15:0] htype;
    logic [15:0] ptype;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    mac_t        sha;
    ipv4_t       spa;
    mac_t        tha;
    ipv4_t       tpa;
  } arp_hdr_t;

  // the shifters see bytes, the logic sees fields.
  typedef union packed {
    arp_hdr_t                        hdr;
    logic [ARP_HDR_LEN-1:0][7:0]     bytes;
  } arp_word_u;

endpackage

// File: src/arp_rx.sv
`timescale 1ns/1ps

module arp_rx (
  input  logic           clk,
  input  logic           fsm_rst,
  input  logic           rx_val,
  input  logic           rx_sof,
  input  logic           rx_eof,
  input  logic [7:0]     rx_dat,
  output logic           hdr_val,
  output logic [15:0]    oper,
  output arp_pkg::mac_t  sha,
  output arp_pkg::ipv4_t spa,
  output arp_pkg::ipv4_t tpa
);

  import arp_pkg::*;

  enum logic [1:0] {
    idle_s,
    hdr_s,
    pad_s
  } fsm;

  arp_word_u  word;
  arp_word_u  nxt;
  logic [4:0] byte_cnt;
  logic       take;
  logic       last;
  logic       hdr_ok;
  logic       rx_rst;

  assign rx_rst = fsm_rst || (rx_val && rx_eof); // end of packet restarts the parser.
  assign take   = rx_val && ((fsm == idle_s && rx_sof) || fsm == hdr_s);
  assign last   = take && (byte_cnt == 5'(ARP_HDR_LEN - 1));

  always_comb begin
    nxt.bytes = {word.bytes[ARP_HDR_LEN-2:0], rx_dat};
  end

  assign hdr_ok = (nxt.hdr.htype == HTYPE_ETH) && (nxt.hdr.ptype == PTYPE_IPV4) &&
                  (nxt.hdr.hlen == HLEN_MAC) && (nxt.hdr.plen == PLEN_IPV4);

  always_ff @(posedge clk) begin
    if (rx_rst) begin
      fsm      <= idle_s;
      byte_cnt <= '0;
    end else begin
      case (fsm)
        idle_s: begin
          if (take) begin
            fsm      <= hdr_s;
            byte_cnt <= 5'd1;
          end
        end
        hdr_s: begin
          if (take) byte_cnt <= byte_cnt + 5'd1;
          if (last) fsm <= pad_s;
        end
        pad_s: begin
          fsm <= pad_s; // pad bytes ignored until rx_eof.
        end
        default: fsm <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) word <= nxt;
  end

  // a 28 byte packet may carry rx_eof on its last byte.
  always_ff @(posedge clk) begin
    if (fsm_rst) hdr_val <= 1'b0;
    else         hdr_val <= last && hdr_ok;
  end

  assign oper = word.hdr.oper;
  assign sha  = word.hdr.sha;
  assign spa  = word.hdr.spa;
  assign tpa  = word.hdr.tpa;

  sof_with_val: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_sof |-> rx_val);

endmodule

// File: src/arp_cache.sv
`timescale 1ns/1ps

module arp_cache (
  input  logic           clk,
  input  logic           fsm_rst,
  input  logic           wr_en,
  input  arp_pkg::ipv4_t wr_ip,
  input  arp_pkg::mac_t  wr_mac,
  input  logic           rd_en,
  input  arp_pkg::ipv4_t rd_ip,
  output logic           rd_val,
  output logic           rd_hit,
  output arp_pkg::mac_t  rd_mac
);

  import arp_pkg::*;

  logic [CACHE_ENTRIES-1:0] ent_val;
  ipv4_t                    ent_ip  [CACHE_ENTRIES];
  mac_t                     ent_mac [CACHE_ENTRIES];
  logic [CACHE_IDX_W-1:0]   wr_idx;
  logic [CACHE_IDX_W-1:0]   rd_idx;

  // direct mapped on the low bits of the last octet.
  assign wr_idx = wr_ip[0][CACHE_IDX_W-1:0];
  assign rd_idx = rd_ip[0][CACHE_IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (fsm_rst) ent_val <= '0;
    else if (wr_en) ent_val[wr_idx] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      ent_ip[wr_idx]  <= wr_ip; // older entry is simply replaced.
      ent_mac[wr_idx] <= wr_mac;
    end
  end

  // same-cycle write is not forwarded, the read sees the old entry.
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rd_val <= 1'b0;
      rd_hit <= 1'b0;
    end else begin
      rd_val <= rd_en;
      rd_hit <= rd_en && ent_val[rd_idx] && (ent_ip[rd_idx] == rd_ip);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) rd_mac <= ent_mac[rd_idx];
  end

endmodule

// File: src/arp_ctrl.sv
`timescale 1ns/1ps

module arp_ctrl (
  input  logic           clk,
  input  logic           fsm_rst,
  input  arp_pkg::ipv4_t dev_ipv4,
  input  logic           hdr_val,
  input  logic [15:0]    oper,
  input  arp_pkg::mac_t  sha,
  input  arp_pkg::ipv4_t spa,
  input  arp_pkg::ipv4_t tpa,
  input  logic           lookup_req,
  input  arp_pkg::ipv4_t lookup_ip,
  input  logic           rd_val,
  input  logic           rd_hit,
  input  arp_pkg::mac_t  rd_mac,
  input  logic           busy,
  output logic           wr_en,
  output arp_pkg::ipv4_t wr_ip,
  output arp_pkg::mac_t  wr_mac,
  output logic           rd_en,
  output arp_pkg::ipv4_t rd_ip,
  output logic           lookup_done,
  output logic           lookup_hit,
  output arp_pkg::mac_t  lookup_mac,
  output logic           send,
  output logic [15:0]    send_oper,
  output arp_pkg::mac_t  send_tha,
  output arp_pkg::ipv4_t send_tpa
);

  import arp_pkg::*;

  logic  rep_pend;
  logic  req_pend;
  mac_t  rep_tha;
  ipv4_t rep_tpa;
  ipv4_t req_tpa;
  ipv4_t look_ip;
  logic  rep_evt;
  logic  req_evt;
  logic  tx_free;
  logic  go_rep;
  logic  go_req;

  assign rd_en   = lookup_req;
  assign rd_ip   = lookup_ip;
  assign rep_evt = hdr_val && (oper == OPER_REQ) && (tpa == dev_ipv4) && !rep_pend;
  assign req_evt = rd_val && !rd_hit && !req_pend;
  assign tx_free = !busy && !send; // busy rises one cycle after send.
  assign go_rep  = tx_free && rep_pend;
  assign go_req  = tx_free && req_pend && !rep_pend; // replies go first.

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_en       <= 1'b0;
      lookup_done <= 1'b0;
      lookup_hit  <= 1'b0;
      rep_pend    <= 1'b0;
      req_pend    <= 1'b0;
      send        <= 1'b0;
    end else begin
      wr_en       <= hdr_val && (oper == OPER_REQ || oper == OPER_REP);
      lookup_done <= rd_val;
      lookup_hit  <= rd_hit;
      send        <= go_rep || go_req;
      if (go_rep) rep_pend <= 1'b0;
      if (go_req) req_pend <= 1'b0;
      if (rep_evt) rep_pend <= 1'b1;
      if (req_evt) req_pend <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_val) begin
      wr_ip  <= spa;
      wr_mac <= sha;
    end
    if (lookup_req) look_ip <= lookup_ip;
    if (rd_val) lookup_mac <= rd_mac;
    if (rep_evt) begin
      rep_tha <= sha; // reply goes back to the asking host.
      rep_tpa <= spa;
    end
    if (req_evt) req_tpa <= look_ip;
    if (go_rep) begin
      send_oper <= OPER_REP;
      send_tha  <= rep_tha;
      send_tpa  <= rep_tpa;
    end else if (go_req) begin
      send_oper <= OPER_REQ;
      send_tha  <= '0;
      send_tpa  <= req_tpa;
    end
  end

  no_send_while_busy: assert property (@(posedge clk) disable iff (fsm_rst)
    send |-> !busy);

endmodule

// File: src/arp_tx.sv
`timescale 1ns/1ps

module arp_tx (
  input  logic           clk,
  input  logic           fsm_rst,
  input  arp_pkg::mac_t  dev_mac,
  input  arp_pkg::ipv4_t dev_ipv4,
  input  logic           send,
  input  logic [15:0]    send_oper,
  input  arp_pkg::mac_t  send_tha,
  input  arp_pkg::ipv4_t send_tpa,
  output logic           tx_val,
  output logic           tx_sof,
  output logic           tx_eof,
  output logic [7:0]     tx_dat,
  output arp_pkg::mac_t  tx_dst_mac,
  output logic           busy,
  output logic           done
);

  import arp_pkg::*;

  enum logic [1:0] {
    idle_s,
    delay_s,
    tx_s
  } fsm;

  arp_word_u  word;
  logic [5:0] byte_cnt;
  logic       load;
  logic       tx_rst;

  assign tx_rst = fsm_rst || done; // last byte returns the fsm to idle.
  assign load   = (fsm == idle_s) && send;
  assign tx_dat = word.bytes[ARP_HDR_LEN-1];

  always_ff @(posedge clk) begin
    if (tx_rst) begin
      fsm      <= idle_s;
      tx_val   <= 1'b0;
      tx_sof   <= 1'b0;
      tx_eof   <= 1'b0;
      busy     <= 1'b0;
      done     <= 1'b0;
      byte_cnt <= '0;
    end else begin
      case (fsm)
        idle_s: begin
          if (send) begin
            fsm  <= delay_s;
            busy <= 1'b1;
          end
        end
        delay_s: begin
          fsm    <= tx_s;
          tx_val <= 1'b1;
          tx_sof <= 1'b1;
        end
        tx_s: begin
          tx_sof   <= 1'b0;
          byte_cnt <= byte_cnt + 6'd1;
          if (byte_cnt == 6'(ARP_PLD_LEN - 2)) begin
            tx_eof <= 1'b1;
            done   <= 1'b1;
          end
        end
        default: fsm <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      word.hdr <= '{
        htype: HTYPE_ETH,
        ptype: PTYPE_IPV4,
        hlen:  HLEN_MAC,
        plen:  PLEN_IPV4,
        oper:  send_oper,
        sha:   dev_mac,
        spa:   dev_ipv4,
        tha:   send_tha,
        tpa:   send_tpa
      };
      tx_dst_mac <= (send_oper == OPER_REQ) ? BCAST_MAC : send_tha;
    end else if (fsm == tx_s) begin
      // zeros shifted in become the pad after byte 28.
      word.bytes <= {word.bytes[ARP_HDR_LEN-2:0], 8'h00};
    end
  end

  // eof marks the 46th byte after sof.
  eof_with_val: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_eof |-> tx_val && $past(tx_sof, ARP_PLD_LEN - 1));

endmodule

// File: src/arp_top.sv
`timescale 1ns/1ps

module arp_top (
  input  logic           clk,
  input  logic           fsm_rst,
  input  arp_pkg::mac_t  dev_mac,
  input  arp_pkg::ipv4_t dev_ipv4,
  input  logic           rx_val,
  input  logic           rx_sof,
  input  logic           rx_eof,
  input  logic [7:0]     rx_dat,
  input  logic           lookup_req,
  input  arp_pkg::ipv4_t lookup_ip,
  output logic           lookup_done,
  output logic           lookup_hit,
  output arp_pkg::mac_t  lookup_mac,
  output logic           tx_val,
  output logic           tx_sof,
  output logic           tx_eof,
  output logic [7:0]     tx_dat,
  output arp_pkg::mac_t  tx_dst_mac,
  output logic           tx_busy
);

  import arp_pkg::*;

  logic        hdr_val;
  logic [15:0] oper;
  mac_t        sha;
  ipv4_t       spa;
  ipv4_t       tpa;
  logic        wr_en;
  ipv4_t       wr_ip;
  mac_t        wr_mac;
  logic        rd_en;
  ipv4_t       rd_ip;
  logic        rd_val;
  logic        rd_hit;
  mac_t        rd_mac;
  logic        send;
  logic [15:0] send_oper;
  mac_t        send_tha;
  ipv4_t       send_tpa;

  arp_rx u_rx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx_val  (rx_val),
    .rx_sof  (rx_sof),
    .rx_eof  (rx_eof),
    .rx_dat  (rx_dat),
    .hdr_val (hdr_val),
    .oper    (oper),
    .sha     (sha),
    .spa     (spa),
    .tpa     (tpa)
  );

  arp_ctrl u_ctrl (
    .clk         (clk),
    .fsm_rst     (fsm_rst),
    .dev_ipv4    (dev_ipv4),
    .hdr_val     (hdr_val),
    .oper        (oper),
    .sha         (sha),
    .spa         (spa),
    .tpa         (tpa),
    .lookup_req  (lookup_req),
    .lookup_ip   (lookup_ip),
    .rd_val      (rd_val),
    .rd_hit      (rd_hit),
    .rd_mac      (rd_mac),
    .busy        (tx_busy),
    .wr_en       (wr_en),
    .wr_ip       (wr_ip),
    .wr_mac      (wr_mac),
    .rd_en       (rd_en),
    .rd_ip       (rd_ip),
    .lookup_done (lookup_done),
    .lookup_hit  (lookup_hit),
    .lookup_mac  (lookup_mac),
    .send        (send),
    .send_oper   (send_oper),
    .send_tha    (send_tha),
    .send_tpa    (send_tpa)
  );

  arp_cache u_cache (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr_en   (wr_en),
    .wr_ip   (wr_ip),
    .wr_mac  (wr_mac),
    .rd_en   (rd_en),
    .rd_ip   (rd_ip),
    .rd_val  (rd_val),
    .rd_hit  (rd_hit),
    .rd_mac  (rd_mac)
  );

  // done only feeds the transmitter's own restart.
  arp_tx u_tx (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .dev_mac    (dev_mac),
    .dev_ipv4   (dev_ipv4),
    .send       (send),
    .send_oper  (send_oper),
    .send_tha   (send_tha),
    .send_tpa   (send_tpa),
    .tx_val     (tx_val),
    .tx_sof     (tx_sof),
    .tx_eof     (tx_eof),
    .tx_dat     (tx_dat),
    .tx_dst_mac (tx_dst_mac),
    .busy       (tx_busy),
    .done       ()
  );

endmodule

// File: testbench/arp_model.sv
`timescale 1ns/1ps

module arp_model;

  import arp_pkg::*;

  logic        ent_val [CACHE_ENTRIES];
  logic [31:0] ent_ip  [CACHE_ENTRIES];
  logic [47:0] ent_mac [CACHE_ENTRIES];
  logic [7:0]  exp_pld [ARP_PLD_LEN];
  logic [47:0] exp_dst;

  task automatic clear();
    for (int i = 0; i < CACHE_ENTRIES; i++) ent_val[i] = 1'b0;
  endtask

  // direct mapped, a new sender replaces whatever shares its low bits.
  task automatic learn(input logic [31:0] ip, input logic [47:0] mac);
    ent_val[ip[CACHE_IDX_W-1:0]] = 1'b1;
    ent_ip[ip[CACHE_IDX_W-1:0]]  = ip;
    ent_mac[ip[CACHE_IDX_W-1:0]] = mac;
  endtask

  function automatic logic hit(input logic [31:0] ip);
    return ent_val[ip[CACHE_IDX_W-1:0]] && (ent_ip[ip[CACHE_IDX_W-1:0]] == ip);
  endfunction

  function automatic logic [47:0] mac_of(input logic [31:0] ip);
    return ent_mac[ip[CACHE_IDX_W-1:0]];
  endfunction

  // header fields in wire order.
  function automatic logic [223:0] header(
    input logic [15:0] htype, input logic [15:0] ptype, input logic [7:0] hlen,
    input logic [7:0] plen, input logic [15:0] oper, input logic [47:0] sha,
    input logic [31:0] spa, input logic [47:0] tha, input logic [31:0] tpa);
    return {htype, ptype, hlen, plen, oper, sha, spa, tha, tpa};
  endfunction

  task automatic expect_tx(input logic [15:0] oper, input logic [47:0] sha,
                           input logic [31:0] spa, input logic [47:0] tha,
                           input logic [31:0] tpa);
    logic [367:0] pld;
    pld = {header(16'h0001, 16'h0800, 8'd6, 8'd4, oper, sha, spa, tha, tpa), 144'h0}; // 18 pad.
    for (int i = 0; i < ARP_PLD_LEN; i++) exp_pld[i] = pld[367 - 8*i -: 8];
    exp_dst = (oper == 16'd1) ? 48'hffff_ffff_ffff : tha;
  endtask

endmodule

// File: testbench/arp_tb.sv
`timescale 1ns/1ps

module arp_tb;

  import arp_pkg::*;

  localparam int N_RAND  = 40;
  localparam int N_TRANS = N_RAND + 24;
  localparam int LIMIT   = 300 * N_TRANS;

  logic        clk = 1'b0;
  logic        fsm_rst;
  logic [47:0] dev_mac;
  logic [31:0] dev_ipv4;
  logic        rx_val;
  logic        rx_sof;
  logic        rx_eof;
  logic [7:0]  rx_dat;
  logic        lookup_req;
  logic [31:0] lookup_ip;
  logic        lookup_done;
  logic        lookup_hit;
  logic [47:0] lookup_mac;
  logic        tx_val;
  logic        tx_sof;
  logic        tx_eof;
  logic [7:0]  tx_dat;
  logic [47:0] tx_dst_mac;
  logic        tx_busy;
  logic [31:0] lfsr = 32'ha7d7;
  int          cycles = 0;

  arp_top uut (.*);

  arp_model model ();

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] val);
    val = '0;
    repeat (n) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // sixteen hosts on one subnet, so cache slots collide.
  task automatic pick_host(output logic [31:0] ip);
    logic [31:0] r;
    draw(4, r);
    ip = {24'hc0a801, 4'h1, r[3:0]};
  endtask

  task automatic drive_rx(input logic [223:0] hdr, input int nbytes, input logic gaps);
    logic [31:0] r;
    for (int i = 0; i < nbytes; i++) begin
      r = '0;
      if (gaps) draw(2, r);
      repeat (r[1:0]) begin
        @(posedge clk);
        rx_val <= 1'b0;
        rx_sof <= 1'b0;
        rx_eof <= 1'b0;
      end
      @(posedge clk);
      rx_val <= 1'b1;
      rx_sof <= (i == 0);
      rx_eof <= (i == nbytes - 1);
      rx_dat <= hdr[223:216];
      hdr = hdr << 8; // zeros become the pad.
    end
    @(posedge clk);
    rx_val <= 1'b0;
    rx_sof <= 1'b0;
    rx_eof <= 1'b0;
  endtask

  task automatic receive_tx();
    @(negedge clk);
    while (!tx_sof) @(negedge clk);
    for (int i = 0; i < ARP_PLD_LEN; i++) begin
      check(tx_val, 1'b1, $sformatf("tx_val byte %0d", i));
      check(tx_sof, i == 0, $sformatf("tx_sof byte %0d", i));
      check(tx_eof, i == ARP_PLD_LEN - 1, $sformatf("tx_eof byte %0d", i));
      check(tx_dat, model.exp_pld[i], $sformatf("tx_dat byte %0d", i));
      check(tx_dst_mac, model.exp_dst, $sformatf("tx_dst_mac byte %0d", i));
      @(negedge clk);
    end
    check(tx_val, 1'b0, "tx_val after last byte");
    check(tx_busy, 1'b0, "tx_busy after last byte");
  endtask

  task automatic quiet_check(input int n);
    repeat (n) begin
      @(negedge clk);
      check(tx_busy, 1'b0, "tx_busy with nothing to send");
      check(tx_val, 1'b0, "tx_val with nothing to send");
    end
  endtask

  task automatic lookup(input logic [31:0] ip);
    logic        exp_hit;
    logic [47:0] exp_mac;
    exp_hit = model.hit(ip);
    exp_mac = model.mac_of(ip);
    @(posedge clk);
    lookup_req <= 1'b1;
    lookup_ip  <= ip;
    @(posedge clk);
    lookup_req <= 1'b0;
    @(negedge clk);
    check(lookup_done, 1'b0, "lookup_done one cycle after lookup_req");
    @(negedge clk);
    check(lookup_done, 1'b1, "lookup_done two cycles after lookup_req");
    check(lookup_hit, exp_hit, "lookup_hit");
    if (exp_hit) begin
      check(lookup_mac, exp_mac, "lookup_mac");
      quiet_check(12);
    end else begin
      model.expect_tx(OPER_REQ, dev_mac, dev_ipv4, 48'h0, ip); // broadcast request.
      receive_tx();
    end
  endtask

  // kind 0 request for us, 1 reply, 2 request for another host,
  // 3..6 one bad header field, 7 cut short.
  task automatic rx_packet(input int kind, input logic gaps, input logic [31:0] fixed_ip,
                           output logic [31:0] sender);
    logic [31:0]  r;
    logic [31:0]  spa;
    logic [47:0]  sha;
    logic [15:0]  htype;
    logic [15:0]  ptype;
    logic [7:0]   hlen;
    logic [7:0]   plen;
    logic [223:0] hdr;
    int           nbytes;
    if (fixed_ip != 0) spa = fixed_ip;
    else pick_host(spa);
    draw(32, r);
    sha[31:0] = r;
    draw(16, r);
    sha[47:32] = r[15:0];
    htype  = 16'h0001;
    ptype  = 16'h0800;
    hlen   = 8'd6;
    plen   = 8'd4;
    nbytes = ARP_PLD_LEN;
    case (kind)
      3: htype = 16'h0006;
      4: ptype = 16'h86dd;
      5: hlen = 8'd8;
      6: plen = 8'd16;
      7: begin
        draw(5, r);
        nbytes = 1 + int'(r % 27);
      end
      default: ;
    endcase
    hdr = model.header(htype, ptype, hlen, plen, (kind == 1) ? 16'd2 : 16'd1, sha, spa,
                       (kind == 1) ? dev_mac : 48'h0,
                       (kind == 2) ? 32'hc0a8_01c8 : dev_ipv4);
    if (kind < 3) model.learn(spa, sha);
    if (kind == 0) model.expect_tx(OPER_REP, dev_mac, dev_ipv4, sha, spa);
    fork
      drive_rx(hdr, nbytes, gaps);
      if (kind == 0) receive_tx();
      else quiet_check(4 * nbytes + 12);
    join
    sender = spa;
  endtask

  initial begin
    logic [31:0] ip;
    logic [31:0] r;
    logic [31:0] g;
    fsm_rst    = 1'b1;
    dev_mac    = 48'h02_1a_2b_3c_4d_5e;
    dev_ipv4   = 32'hc0a8_0164;
    rx_val     = 1'b0;
    rx_sof     = 1'b0;
    rx_eof     = 1'b0;
    rx_dat     = 8'h00;
    lookup_req = 1'b0;
    lookup_ip  = 32'h0;
    model.clear();
    repeat (10) @(posedge clk);
    fsm_rst <= 1'b0;

    pick_host(ip); // empty cache, so this one misses.
    lookup(ip);
    rx_packet(0, 1'b0, 32'h0, ip);
    lookup(ip);
    rx_packet(1, 1'b0, 32'h0, ip);
    lookup(ip);
    rx_packet(2, 1'b0, 32'h0, ip);
    lookup(ip);
    // both land in slot 3, the later one stays.
    rx_packet(1, 1'b0, 32'hc0a8_0113, ip);
    rx_packet(2, 1'b0, 32'hc0a8_011b, ip);
    lookup(32'hc0a8_0113);
    lookup(32'hc0a8_011b);
    for (int k = 3; k < 8; k++) begin
      rx_packet(k, 1'b0, 32'h0, ip);
      lookup(ip);
    end
    rx_packet(0, 1'b1, 32'h0, ip);
    lookup(ip);

    for (int n = 0; n < N_RAND; n++) begin
      draw(4, r);
      draw(1, g);
      if (r[3]) begin
        pick_host(ip);
        lookup(ip);
      end else begin
        rx_packet(int'(r[2:0]), g[0], 32'h0, ip);
      end
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: verilog.f
src/arp_pkg.sv
src/arp_rx.sv
src/arp_cache.sv
src/arp_ctrl.sv
src/arp_tx.sv
src/arp_top.sv
testbench/arp_model.sv
testbench/arp_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module arp_tb -o arp_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/arp_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi
if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
